// File: tb.f
hdl/respbank_pkg.sv
hdl/slot_allocator.sv
hdl/link_table.sv
hdl/payload_ram.sv
hdl/list_pointers.sv
hdl/release_picker.sv
hdl/resp_bank_top.sv
bench/tb_resp_bank.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the response bank testbench with Verilator and runs it
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f tb.f \
  --top-module tb_resp_bank \
  -o sim_resp_bank

./obj_dir/sim_resp_bank | tee sim.log

if grep -q "tests failed" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation finished without failures"

// File: bench/tb_resp_bank.sv
`timescale 1ns/1ps
`default_nettype none

module tb_resp_bank import respbank_pkg::*; ();

  logic                     clk_i;
  logic                     rst_ni;
  logic                     rsv_valid;
  logic [NumIds-1:0]        rsv_id_onehot;
  logic                     rsv_ready;
  logic [SlotAddrWidth-1:0] rsv_addr;
  logic                     in_valid;
  logic [IdWidth-1:0]       in_id;
  logic [PayloadWidth-1:0]  in_payload;
  logic                     in_ready;
  logic [BankCapacity-1:0]  release_en;
  logic                     out_valid;
  logic                     out_ready;
  logic [IdWidth-1:0]       out_id;
  logic [PayloadWidth-1:0]  out_payload;
  logic [BankCapacity-1:0]  released_addr;

  // Reference model of the bank
  // A set bit in free_slots marks a slot that no reservation holds
  logic [BankCapacity-1:0] free_slots;
  // Reserved slots still waiting for their response, oldest first
  logic [SlotAddrWidth-1:0] unfilled_q [NumIds][$];
  // Stored responses as {slot, payload}, in input order
  logic [SlotAddrWidth+PayloadWidth-1:0] filled_q [NumIds][$];

  logic [31:0] rng_state = 32'd27730;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  resp_bank_top i_resp_bank_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .i_rsv_valid     (rsv_valid),
    .i_rsv_id_onehot (rsv_id_onehot),
    .o_rsv_ready     (rsv_ready),
    .o_rsv_addr      (rsv_addr),
    .i_in_valid      (in_valid),
    .i_in_id         (in_id),
    .i_in_payload    (in_payload),
    .o_in_ready      (in_ready),
    .i_release_en    (release_en),
    .o_out_valid     (out_valid),
    .i_out_ready     (out_ready),
    .o_out_id        (out_id),
    .o_out_payload   (out_payload),
    .o_released_addr (released_addr)
  );

  // 40 ns clock period
  always #20 clk_i = ~clk_i;

  //////////////////////////////
  // Helpers and model
  //////////////////////////////

  // 32-bit xorshift that supplies payloads, ids and the ready pattern
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [SlotAddrWidth-1:0] lowest_free();
    logic [SlotAddrWidth-1:0] addr;
    logic found;
    addr = '0;
    found = 1'b0;
    for (int i = 0; i < BankCapacity; i++) begin
      if (free_slots[i] && !found) begin
        addr = SlotAddrWidth'(i);
        found = 1'b1;
      end
    end
    return addr;
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int i = 0; i < NumIds; i++) begin
      n += unfilled_q[i].size();
    end
    return n;
  endfunction

  function automatic int stored_count();
    int n;
    n = 0;
    for (int i = 0; i < NumIds; i++) begin
      n += filled_q[i].size();
    end
    return n;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected == actual) else begin
      $display("CHECK FAILED at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // One reservation whose shown address must be the lowest free slot
  // The slot handed back is the address that the DUT showed
  task automatic reserve_slot(input logic [IdWidth-1:0] id,
                              output logic [SlotAddrWidth-1:0] slot);
    logic [SlotAddrWidth-1:0] exp_slot;
    @(negedge clk_i);
    rsv_valid = 1'b1;
    rsv_id_onehot = '0;
    rsv_id_onehot[id] = 1'b1;
    #1;
    exp_slot = lowest_free();
    slot = rsv_addr;
    check_value("o_rsv_ready", 32'(1), 32'(rsv_ready));
    check_value("o_rsv_addr", 32'(exp_slot), 32'(rsv_addr));
    @(negedge clk_i);
    rsv_valid = 1'b0;
    rsv_id_onehot = '0;
    free_slots[exp_slot] = 1'b0;
    unfilled_q[id].push_back(exp_slot);
  endtask

  // One response that lands in the oldest unfilled slot of its id
  task automatic fill_resp(input logic [IdWidth-1:0] id, input logic [PayloadWidth-1:0] payload);
    logic [SlotAddrWidth-1:0] slot;
    @(negedge clk_i);
    in_valid = 1'b1;
    in_id = id;
    in_payload = payload;
    #1;
    check_value("o_in_ready", 32'(1), 32'(in_ready));
    @(negedge clk_i);
    in_valid = 1'b0;
    slot = unfilled_q[id].pop_front();
    filled_q[id].push_back({slot, payload});
  endtask

  // Fills one pending reservation, starting the search at a random id
  task automatic fill_one_random();
    logic [IdWidth-1:0] start;
    logic [IdWidth-1:0] id;
    logic done;
    start = IdWidth'(next_random());
    done = 1'b0;
    for (int k = 0; k < NumIds; k++) begin
      id = IdWidth'(start + k);
      if (!done && unfilled_q[id].size() > 0) begin
        fill_resp(id, PayloadWidth'(next_random()));
        done = 1'b1;
      end
    end
  endtask

  task automatic fill_all_pending();
    while (pending_count() > 0) begin
      fill_one_random();
    end
  endtask

  // Takes count responses and checks each against the model
  // A stalled response must keep its id and payload until it is taken
  task automatic drain_outputs(input int count, input logic random_ready);
    int taken;
    int cycles;
    logic held;
    logic [IdWidth-1:0] held_id;
    logic [PayloadWidth-1:0] held_payload;
    logic [SlotAddrWidth+PayloadWidth-1:0] entry;
    logic [BankCapacity-1:0] exp_rel;
    taken = 0;
    cycles = 0;
    held = 1'b0;
    held_id = '0;
    held_payload = '0;
    while (taken < count && cycles < count * 20) begin
      @(negedge clk_i);
      out_ready = random_ready ? 1'(next_random()) : 1'b1;
      #1;
      exp_rel = '0;
      if (held) begin
        assert (out_valid) else begin
          $display("Output valid dropped at %0t before the response was taken", $time);
          errors++;
        end
        check_value("o_out_id", 32'(held_id), 32'(out_id));
        check_value("o_out_payload", 32'(held_payload), 32'(out_payload));
      end
      if (out_valid && out_ready) begin
        assert (filled_q[out_id].size() > 0) else begin
          $display("Response for id %0d came out at %0t with nothing stored", out_id, $time);
          errors++;
        end
        if (filled_q[out_id].size() > 0) begin
          entry = filled_q[out_id].pop_front();
          check_value("o_out_payload", 32'(entry[PayloadWidth-1:0]), 32'(out_payload));
          exp_rel[entry[PayloadWidth +: SlotAddrWidth]] = 1'b1;
          free_slots[entry[PayloadWidth +: SlotAddrWidth]] = 1'b1;
        end
        taken++;
        held = 1'b0;
      end else begin
        held = out_valid;
        held_id = out_id;
        held_payload = out_payload;
      end
      check_value("o_released_addr", 32'(exp_rel), 32'(released_addr));
      cycles++;
    end
    assert (taken == count) else begin
      $display("Only %0d of %0d responses came out before the wait ran out", taken, count);
      errors++;
    end
    @(negedge clk_i);
    out_ready = 1'b0;
  endtask

  task automatic finish_test(input string name, input int errors_at_start);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - errors_at_start);
      tests_failed++;
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic after_reset_idle();
    int start;
    start = errors;
    @(negedge clk_i);
    #1;
    check_value("o_rsv_ready", 32'(1), 32'(rsv_ready));
    check_value("o_rsv_addr", 32'(0), 32'(rsv_addr));
    check_value("o_out_valid", 32'(0), 32'(out_valid));
    check_value("o_in_ready", 32'(0), 32'(in_ready));
    check_value("o_released_addr", 32'(0), 32'(released_addr));
    finish_test("after_reset_idle", start);
  endtask

  task automatic fill_whole_bank();
    int start;
    logic [SlotAddrWidth-1:0] slot;
    start = errors;
    // Slots come out in address order while the ids rotate
    for (int k = 0; k < BankCapacity; k++) begin
      reserve_slot(IdWidth'(k), slot);
      check_value("o_rsv_addr", 32'(k), 32'(slot));
    end
    #1;
    check_value("o_rsv_ready", 32'(0), 32'(rsv_ready));
    fill_all_pending();
    drain_outputs(BankCapacity, 1'b0);
    #1;
    check_value("o_rsv_ready", 32'(1), 32'(rsv_ready));
    check_value("o_rsv_addr", 32'(0), 32'(rsv_addr));
    finish_test("fill_whole_bank", start);
  endtask

  task automatic refuse_unreserved_input();
    int start;
    logic [SlotAddrWidth-1:0] slot;
    start = errors;
    for (int k = 0; k < NumIds; k++) begin
      @(negedge clk_i);
      in_valid = 1'b1;
      in_id = IdWidth'(k);
      #1;
      check_value("o_in_ready", 32'(0), 32'(in_ready));
    end
    @(negedge clk_i);
    in_valid = 1'b0;
    // A reservation for id 2 must not open the input for id 0
    reserve_slot(IdWidth'(2), slot);
    @(negedge clk_i);
    in_valid = 1'b1;
    in_id = IdWidth'(0);
    #1;
    check_value("o_in_ready", 32'(0), 32'(in_ready));
    fill_resp(IdWidth'(2), PayloadWidth'(next_random()));
    drain_outputs(1, 1'b0);
    finish_test("refuse_unreserved_input", start);
  endtask

  task automatic interleaved_ordering();
    int start;
    logic [SlotAddrWidth-1:0] slot;
    start = errors;
    for (int k = 0; k < BankCapacity; k++) begin
      reserve_slot(IdWidth'(next_random()), slot);
      if (1'(next_random())) begin
        fill_one_random();
      end
    end
    fill_all_pending();
    drain_outputs(BankCapacity, 1'b0);
    finish_test("interleaved_ordering", start);
  endtask

  task automatic release_gating();
    int start;
    logic [SlotAddrWidth-1:0] slot_a;
    logic [SlotAddrWidth-1:0] slot_b;
    start = errors;
    @(negedge clk_i);
    release_en = '0;
    reserve_slot(IdWidth'(1), slot_a);
    reserve_slot(IdWidth'(3), slot_b);
    fill_resp(IdWidth'(1), PayloadWidth'(next_random()));
    fill_resp(IdWidth'(3), PayloadWidth'(next_random()));
    for (int k = 0; k < 16; k++) begin
      @(negedge clk_i);
      #1;
      assert (!out_valid) else begin
        $display("A response came out at %0t while its release enable was low", $time);
        errors++;
      end
    end
    // Only the slot of id 3 is released, so id 1 must stay inside
    @(negedge clk_i);
    release_en[slot_b] = 1'b1;
    drain_outputs(1, 1'b0);
    check_value("responses left for id 3", 32'(0), 32'(filled_q[3].size()));
    check_value("responses left for id 1", 32'(1), 32'(filled_q[1].size()));
    for (int k = 0; k < 8; k++) begin
      @(negedge clk_i);
      #1;
      check_value("o_out_valid", 32'(0), 32'(out_valid));
    end
    // Now the slot of id 1 opens as well
    @(negedge clk_i);
    release_en[slot_a] = 1'b1;
    drain_outputs(1, 1'b0);
    check_value("responses left for id 1", 32'(0), 32'(filled_q[1].size()));
    release_en = '1;
    finish_test("release_gating", start);
  endtask

  task automatic backpressure_and_reuse();
    int start;
    logic [SlotAddrWidth-1:0] slot;
    start = errors;
    for (int k = 0; k < BankCapacity; k++) begin
      reserve_slot(IdWidth'(next_random()), slot);
    end
    fill_all_pending();
    drain_outputs(4, 1'b1);
    // Freed slots are scattered and reservations must still take the lowest
    for (int k = 0; k < 4; k++) begin
      reserve_slot(IdWidth'(next_random()), slot);
    end
    fill_all_pending();
    drain_outputs(stored_count(), 1'b1);
    #1;
    check_value("o_rsv_ready", 32'(1), 32'(rsv_ready));
    check_value("o_rsv_addr", 32'(0), 32'(rsv_addr));
    finish_test("backpressure_and_reuse", start);
  endtask

  //////////////////////////////
  // Sequence and report
  //////////////////////////////

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    rsv_valid = 1'b0;
    rsv_id_onehot = '0;
    in_valid = 1'b0;
    in_id = '0;
    in_payload = '0;
    release_en = '1;
    out_ready = 1'b0;
    free_slots = '1;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;

    after_reset_idle();
    fill_whole_bank();
    refuse_unreserved_input();
    interleaved_ordering();
    release_gating();
    backpressure_and_reuse();

    $display("%0d tests run, %0d with errors, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Six tests at 200 cycles of 40 ns each
  initial begin
    #(6 * 200 * 40);
    $display("Watchdog expired at %0t with tests still running", $time);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/resp_bank_top.sv
`timescale 1ns/1ps
`default_nettype none

module resp_bank_top import respbank_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Reservation
  input  logic                     i_rsv_valid,
  input  logic [NumIds-1:0]        i_rsv_id_onehot,
  output logic                     o_rsv_ready,
  output logic [SlotAddrWidth-1:0] o_rsv_addr,
  // Response input
  input  logic                     i_in_valid,
  input  logic [IdWidth-1:0]       i_in_id,
  input  logic [PayloadWidth-1:0]  i_in_payload,
  output logic                     o_in_ready,
  // Release enables, one per slot
  input  logic [BankCapacity-1:0]  i_release_en,
  // Response output
  output logic                     o_out_valid,
  input  logic                     i_out_ready,
  output logic [IdWidth-1:0]       o_out_id,
  output logic [PayloadWidth-1:0]  o_out_payload,
  output logic [BankCapacity-1:0]  o_released_addr
);

  logic                     rsv_fire;
  logic                     out_fire;
  logic [SlotAddrWidth-1:0] fill_addr;
  logic                     pop_fire;
  logic [IdWidth-1:0]       pop_id;
  logic [SlotAddrWidth-1:0] rd_addr;
  logic [SlotAddrWidth-1:0] out_slot;
  logic [SlotAddrWidth-1:0] tails [NumIds];
  logic [NumIds-1:0]        has_resp;
  logic                     link_wr_en;
  logic [SlotAddrWidth-1:0] link_wr_addr;
  logic [SlotAddrWidth-1:0] link_wr_next;
  logic [SlotAddrWidth-1:0] link_head_addr;
  logic [SlotAddrWidth-1:0] link_tail_addr;
  logic [SlotAddrWidth-1:0] link_head_next;
  logic [SlotAddrWidth-1:0] link_tail_next;

  // Handshake strobes
  assign rsv_fire = i_rsv_valid && o_rsv_ready;
  assign out_fire = o_out_valid && i_out_ready;

  slot_allocator i_slot_allocator (
    .clk_i, .rst_ni,
    .i_rsv_fire      (rsv_fire),
    .i_pop_fire      (out_fire),
    .i_out_slot      (out_slot),
    .o_free_addr     (o_rsv_addr),
    .o_rsv_ready     (o_rsv_ready),
    .o_released_addr (o_released_addr)
  );

  link_table i_link_table (
    .clk_i, .rst_ni,
    .i_wr_en        (link_wr_en),
    .i_wr_addr      (link_wr_addr),
    .i_wr_next      (link_wr_next),
    .i_rd_head_addr (link_head_addr),
    .i_rd_tail_addr (link_tail_addr),
    .o_head_next    (link_head_next),
    .o_tail_next    (link_tail_next)
  );

  // The payload is written at the input handshake and read at the pick
  payload_ram i_payload_ram (
    .clk_i,
    .i_wr_en   (o_in_ready),
    .i_wr_addr (fill_addr),
    .i_rd_addr (rd_addr),
    .i_wr_data (i_in_payload),
    .i_rd_en   (pop_fire),
    .o_rd_data (o_out_payload)
  );

  list_pointers i_list_pointers (
    .clk_i, .rst_ni,
    .i_rsv_fire       (rsv_fire),
    .i_rsv_id_onehot  (i_rsv_id_onehot),
    .i_free_addr      (o_rsv_addr),
    .i_in_valid       (i_in_valid),
    .i_in_id          (i_in_id),
    .o_in_ready       (o_in_ready),
    .o_fill_addr      (fill_addr),
    .i_pop_fire       (pop_fire),
    .i_pop_id         (pop_id),
    .o_tails          (tails),
    .o_has_resp       (has_resp),
    .o_link_wr_en     (link_wr_en),
    .o_link_wr_addr   (link_wr_addr),
    .o_link_wr_next   (link_wr_next),
    .o_link_head_addr (link_head_addr),
    .o_link_tail_addr (link_tail_addr),
    .i_link_head_next (link_head_next),
    .i_link_tail_next (link_tail_next)
  );

  release_picker i_release_picker (
    .clk_i, .rst_ni,
    .i_release_en (i_release_en),
    .i_tails      (tails),
    .i_has_resp   (has_resp),
    .i_out_ready  (i_out_ready),
    .o_pop_fire   (pop_fire),
    .o_pop_id     (pop_id),
    .o_rd_addr    (rd_addr),
    .o_out_valid  (o_out_valid),
    .o_out_id     (o_out_id),
    .o_out_slot   (out_slot)
  );

endmodule

`default_nettype wire

// File: hdl/release_picker.sv
`timescale 1ns/1ps
`default_nettype none

module release_picker import respbank_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [BankCapacity-1:0]  i_release_en,
  input  logic [SlotAddrWidth-1:0] i_tails [NumIds],
  input  logic [NumIds-1:0]        i_has_resp,
  input  logic                     i_out_ready,
  output logic                     o_pop_fire,
  output logic [IdWidth-1:0]       o_pop_id,
  output logic [SlotAddrWidth-1:0] o_rd_addr,
  output logic                     o_out_valid,
  output logic [IdWidth-1:0]       o_out_id,
  output logic [SlotAddrWidth-1:0] o_out_slot
);

  logic [NumIds-1:0]        eligible;
  logic                     can_load;
  logic [IdWidth-1:0]       pick_id;
  logic                     out_valid_q;
  logic [IdWidth-1:0]       out_id_q;
  logic [SlotAddrWidth-1:0] out_slot_q;

  // An identifier may release once its oldest response has the slot enable set
  for (genvar g = 0; g < NumIds; g++) begin : gen_eligible
    assign eligible[g] = i_has_resp[g] && i_release_en[i_tails[g]];
  end

  // Lowest eligible identifier wins
  always_comb begin
    pick_id = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        pick_id = IdWidth'(i);
      end
    end
  end

  // The output register loads when it is empty or its content is being taken
  assign can_load = !out_valid_q || i_out_ready;

  assign o_pop_fire = can_load && (|eligible);
  assign o_pop_id = pick_id;

  // Payload read starts at the tail of the picked list and lands with the valid bit
  assign o_rd_addr = i_tails[pick_id];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
      out_id_q <= '0;
      out_slot_q <= '0;
    end else if (can_load) begin
      out_valid_q <= o_pop_fire;
      if (o_pop_fire) begin
        out_id_q <= pick_id;
        out_slot_q <= o_rd_addr;
      end
    end
  end

  assign o_out_valid = out_valid_q;
  assign o_out_id = out_id_q;
  assign o_out_slot = out_slot_q;

  // A new pick never reads the slot that still waits in the output register
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    o_pop_fire && out_valid_q |-> o_rd_addr != out_slot_q);

endmodule

`default_nettype wire

// File: hdl/list_pointers.sv
`timescale 1ns/1ps
`default_nettype none

module list_pointers import respbank_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     i_rsv_fire,
  input  logic [NumIds-1:0]        i_rsv_id_onehot,
  input  logic [SlotAddrWidth-1:0] i_free_addr,
  input  logic                     i_in_valid,
  input  logic [IdWidth-1:0]       i_in_id,
  output logic                     o_in_ready,
  output logic [SlotAddrWidth-1:0] o_fill_addr,
  input  logic                     i_pop_fire,
  input  logic [IdWidth-1:0]       i_pop_id,
  output logic [SlotAddrWidth-1:0] o_tails [NumIds],
  output logic [NumIds-1:0]        o_has_resp,
  output logic                     o_link_wr_en,
  output logic [SlotAddrWidth-1:0] o_link_wr_addr,
  output logic [SlotAddrWidth-1:0] o_link_wr_next,
  output logic [SlotAddrWidth-1:0] o_link_head_addr,
  output logic [SlotAddrWidth-1:0] o_link_tail_addr,
  input  logic [SlotAddrWidth-1:0] i_link_head_next,
  input  logic [SlotAddrWidth-1:0] i_link_tail_next
);

  //////////////////////////////
  // Per-identifier state
  //////////////////////////////

  // In list order a list runs tail, then fill head, then reservation head
  // The tail is the oldest filled slot and the fill head the oldest unfilled one
  // With nothing unfilled the fill head sits on the reservation head
  logic [SlotAddrWidth-1:0] rsv_head_q [NumIds];
  logic [SlotAddrWidth-1:0] rsv_head_d [NumIds];
  logic [SlotAddrWidth-1:0] fill_head_q [NumIds];
  logic [SlotAddrWidth-1:0] fill_head_d [NumIds];
  logic [SlotAddrWidth-1:0] tail_q [NumIds];
  logic [SlotAddrWidth-1:0] tail_d [NumIds];

  // Reserved slots still waiting for a response, and slots holding one
  logic [CountWidth-1:0] rsv_cnt_q [NumIds];
  logic [CountWidth-1:0] rsv_cnt_d [NumIds];
  logic [CountWidth-1:0] fill_cnt_q [NumIds];
  logic [CountWidth-1:0] fill_cnt_d [NumIds];

  logic fill_fire;

  // A response is taken only if its identifier has an unfilled slot
  assign o_in_ready = i_in_valid && (rsv_cnt_q[i_in_id] != '0);
  assign fill_fire = o_in_ready;

  // The response goes into the oldest unfilled slot of its list
  assign o_fill_addr = fill_head_q[i_in_id];

  // Link reads for the fill head advance and the tail advance
  assign o_link_head_addr = fill_head_q[i_in_id];
  assign o_link_tail_addr = tail_q[i_pop_id];

  assign o_tails = tail_q;

  for (genvar g = 0; g < NumIds; g++) begin : gen_has_resp
    assign o_has_resp[g] = fill_cnt_q[g] != '0;
  end

  //////////////////////////////
  // Pointer and count update
  //////////////////////////////

  always_comb begin
    logic rsv_i;
    logic fill_i;
    logic pop_i;
    logic [CountWidth-1:0] left_filled;
    logic [CountWidth-1:0] left_unfilled;

    o_link_wr_en = 1'b0;
    o_link_wr_addr = '0;
    o_link_wr_next = '0;

    for (int i = 0; i < NumIds; i++) begin
      rsv_i = i_rsv_fire && i_rsv_id_onehot[i];
      fill_i = fill_fire && (i_in_id == IdWidth'(i));
      pop_i = i_pop_fire && (i_pop_id == IdWidth'(i));

      // Counts as they stand once this cycle's pop and fill are done
      left_filled = fill_cnt_q[i] - CountWidth'(pop_i);
      left_unfilled = rsv_cnt_q[i] - CountWidth'(fill_i);

      rsv_cnt_d[i] = left_unfilled + CountWidth'(rsv_i);
      fill_cnt_d[i] = left_filled + CountWidth'(fill_i);

      rsv_head_d[i] = rsv_head_q[i];
      fill_head_d[i] = fill_head_q[i];
      tail_d[i] = tail_q[i];

      // The fill head moves on only if another unfilled slot is linked after it
      if (fill_i && (rsv_cnt_q[i] > CountWidth'(1))) begin
        fill_head_d[i] = i_link_head_next;
      end

      // A popped response hands the tail to the next slot in the list
      // When the list runs empty the tail goes stale until the next reservation
      if (pop_i) begin
        tail_d[i] = i_link_tail_next;
      end

      if (rsv_i) begin
        if ((rsv_cnt_q[i] == '0) && (left_filled == '0)) begin
          // An empty list starts over on the new slot
          rsv_head_d[i] = i_free_addr;
          fill_head_d[i] = i_free_addr;
          tail_d[i] = i_free_addr;
        end else begin
          // Chain the new slot behind the current reservation head
          o_link_wr_en = 1'b1;
          o_link_wr_addr = rsv_head_q[i];
          o_link_wr_next = i_free_addr;
          rsv_head_d[i] = i_free_addr;
          // The fill head was parked on a filled slot, so it moves to the new one
          if (left_unfilled == '0) begin
            fill_head_d[i] = i_free_addr;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsv_head_q <= '{default: '0};
      fill_head_q <= '{default: '0};
      tail_q <= '{default: '0};
      rsv_cnt_q <= '{default: '0};
      fill_cnt_q <= '{default: '0};
    end else begin
      rsv_head_q <= rsv_head_d;
      fill_head_q <= fill_head_d;
      tail_q <= tail_d;
      rsv_cnt_q <= rsv_cnt_d;
      fill_cnt_q <= fill_cnt_d;
    end
  end

  // The first response stored for an identifier lands at the tail of its list
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_fire && (fill_cnt_q[i_in_id] == '0) |-> o_fill_addr == tail_q[i_in_id]);

endmodule

`default_nettype wire

// File: hdl/payload_ram.sv
`timescale 1ns/1ps
`default_nettype none

module payload_ram import respbank_pkg::*; (
  input  logic                     clk_i,
  input  logic                     i_wr_en,
  input  logic [SlotAddrWidth-1:0] i_wr_addr,
  input  logic [SlotAddrWidth-1:0] i_rd_addr,
  input  logic [PayloadWidth-1:0]  i_wr_data,
  input  logic                     i_rd_en,
  output logic [PayloadWidth-1:0]  o_rd_data
);

  logic [PayloadWidth-1:0] mem_q [BankCapacity];
  logic [PayloadWidth-1:0] rd_data_q;

  // Write port, used by the response input
  always_ff @(posedge clk_i) begin
    if (i_wr_en) begin
      mem_q[i_wr_addr] <= i_wr_data;
    end
  end

  // Registered read port
  // The data register keeps its value until the next read is started
  always_ff @(posedge clk_i) begin
    if (i_rd_en) begin
      rd_data_q <= mem_q[i_rd_addr];
    end
  end

  assign o_rd_data = rd_data_q;

endmodule

`default_nettype wire

// File: hdl/link_table.sv
`timescale 1ns/1ps
`default_nettype none

module link_table import respbank_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     i_wr_en,
  input  logic [SlotAddrWidth-1:0] i_wr_addr,
  input  logic [SlotAddrWidth-1:0] i_wr_next,
  input  logic [SlotAddrWidth-1:0] i_rd_head_addr,
  input  logic [SlotAddrWidth-1:0] i_rd_tail_addr,
  output logic [SlotAddrWidth-1:0] o_head_next,
  output logic [SlotAddrWidth-1:0] o_tail_next
);

  // Entry n holds the slot that follows slot n in its list
  logic [SlotAddrWidth-1:0] next_q [BankCapacity];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      next_q <= '{default: '0};
    end else if (i_wr_en) begin
      next_q[i_wr_addr] <= i_wr_next;
    end
  end

  // Two read ports, one for the fill head and one for the tail
  // Both see the value before this cycle's write
  assign o_head_next = next_q[i_rd_head_addr];
  assign o_tail_next = next_q[i_rd_tail_addr];

endmodule

`default_nettype wire

// File: hdl/slot_allocator.sv
`timescale 1ns/1ps
`default_nettype none

module slot_allocator import respbank_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     i_rsv_fire,
  input  logic                     i_pop_fire,
  input  logic [SlotAddrWidth-1:0] i_out_slot,
  output logic [SlotAddrWidth-1:0] o_free_addr,
  output logic                     o_rsv_ready,
  output logic [BankCapacity-1:0]  o_released_addr
);

  // One bit per slot, set from reservation until the response leaves the output
  logic [BankCapacity-1:0] occ_q;
  logic [BankCapacity-1:0] occ_d;

  // Lowest free slot, scanning downwards so the lowest index wins
  always_comb begin
    o_free_addr = '0;
    for (int i = BankCapacity - 1; i >= 0; i--) begin
      if (!occ_q[i]) begin
        o_free_addr = SlotAddrWidth'(i);
      end
    end
  end

  // Reservations are refused only when every slot is taken
  assign o_rsv_ready = ~&occ_q;

  // The slot at the output is handed back in the cycle it is taken
  assign o_released_addr = i_pop_fire ? (BankCapacity'(1) << i_out_slot) : '0;

  always_comb begin
    occ_d = occ_q & ~o_released_addr;
    if (i_rsv_fire) begin
      occ_d[o_free_addr] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

  // The slot shown by the output register must still be held by a reservation
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    i_pop_fire |-> occ_q[i_out_slot]);

endmodule

`default_nettype wire

// File: hdl/respbank_pkg.sv
`default_nettype none

//////////////////////////////
// Response bank sizes
//////////////////////////////

package respbank_pkg;

  // Number of AXI identifiers, each with its own linked list
  localparam int unsigned NumIds = 4;
  localparam int unsigned IdWidth = 2;

  // Slots shared by all the lists
  localparam int unsigned BankCapacity = 8;
  localparam int unsigned SlotAddrWidth = 3;

  // Response bits stored in the slot memory, the identifier is not stored
  localparam int unsigned PayloadWidth = 8;

  // Per-identifier counts must be able to reach BankCapacity
  localparam int unsigned CountWidth = 4;

endpackage

`default_nettype wire
